/* store_vectors.txt */
# rnd chk disp rv ridx raddr rsize rdata ret rsv rtail laddr ltail acc
#   spots tail unres fdata fmask valid qaddr qdata qmask (chk: 1 spots 2 fwd 4 valid 8 req)
0 7 2 0 0 00000000 0 00000000 0 0 0 00000000 0 0  2 0 00 00000000 0 0 00000000 00000000 0
0 7 2 0 0 00000000 0 00000000 0 0 0 00000000 0 0  2 2 03 00000000 0 0 00000000 00000000 0
0 7 2 0 0 00000000 0 00000000 0 0 0 00000000 0 0  2 4 0f 00000000 0 0 00000000 00000000 0
0 7 2 0 0 00000000 0 00000000 0 0 0 00000000 0 0  2 6 3f 00000000 0 0 00000000 00000000 0
0 7 0 1 0 00000100 2 11223344 0 0 0 00000000 0 0  0 8 fe 00000000 0 0 00000000 00000000 0
0 7 0 1 1 00000101 0 000000aa 0 0 0 00000100 1 0  0 8 fc 11223344 f 0 00000000 00000000 0
0 7 0 1 2 00000102 1 0000bbcc 0 0 0 00000100 2 0  0 8 f8 1122aa44 f 0 00000000 00000000 0
0 7 0 1 3 00000200 0 00000055 0 0 0 00000100 2 0  0 8 f0 1122aa44 f 0 00000000 00000000 0
0 7 0 0 0 00000000 0 00000000 2 0 0 00000200 4 0  0 8 f0 00000055 1 0 00000000 00000000 0
0 f 0 0 0 00000000 0 00000000 2 0 0 00000100 3 0  0 8 f0 bbccaa44 f 1 00000100 11223344 f
0 f 0 0 0 00000000 0 00000000 0 0 0 00000100 3 0  0 8 f0 bbccaa44 f 1 00000100 11223344 f
0 f 0 0 0 00000000 0 00000000 0 0 0 00000100 3 1  0 8 f0 bbccaa44 f 1 00000100 11223344 f
0 f 0 0 0 00000000 0 00000000 0 0 0 00000100 3 0  1 8 f0 bbccaa00 e 1 00000100 0000aa00 2
0 d 0 0 0 00000000 0 00000000 0 0 0 00000000 0 1  1 8 f0 00000000 0 1 00000100 0000aa00 2
0 d 0 0 0 00000000 0 00000000 0 0 0 00000000 0 1  2 8 f0 00000000 0 1 00000100 bbcc0000 c
0 d 0 0 0 00000000 0 00000000 0 0 0 00000000 0 1  2 8 f0 00000000 0 1 00000200 00000055 1
0 7 0 1 4 00000300 2 cafef00d 0 0 0 00000000 0 0  2 8 e0 00000000 0 0 00000000 00000000 0
0 7 0 1 6 00000300 0 00000077 0 0 0 00000300 8 0  2 8 a0 cafef00d f 0 00000000 00000000 0
0 7 0 0 0 00000000 0 00000000 0 1 6 00000300 8 0  2 8 a0 cafef077 f 0 00000000 00000000 0
0 7 0 0 0 00000000 0 00000000 0 1 c 00000300 6 0  2 6 20 cafef00d f 0 00000000 00000000 0
0 7 0 1 5 00000400 1 00001234 2 0 0 00000000 0 0  0 c 00 00000000 0 0 00000000 00000000 0
1 0 0 0 0 00000000 0 00000000 0 0 0 00000000 0 0  0 c 00 00000000 0 0 00000000 00000000 0
1 0 0 0 0 00000000 0 00000000 0 0 0 00000000 0 0  0 c 00 00000000 0 0 00000000 00000000 0
1 0 0 0 0 00000000 0 00000000 0 0 0 00000000 0 0  0 c 00 00000000 0 0 00000000 00000000 0
0 0 0 0 0 00000000 0 00000000 0 0 0 00000000 0 1  0 c 00 00000000 0 0 00000000 00000000 0
0 0 0 0 0 00000000 0 00000000 0 0 0 00000000 0 1  0 c 00 00000000 0 0 00000000 00000000 0
0 7 0 0 0 00000000 0 00000000 0 0 0 00000000 0 0  2 c 00 00000000 0 0 00000000 00000000 0

/* sim.f */
mem_pkg.sv
sq_pkg.sv
newest_select.sv
store_format.sv
store_forward.sv
store_queue.sv
store_subsystem.sv
tb_store_subsystem.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the store subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal -f sim.f \
        --top-module tb_store_subsystem -Mdir obj_dir; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_store_subsystem > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
if [ "$run_status" -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi
exit 0

/* tb_store_subsystem.sv */
module tb_store_subsystem;
    timeunit 1ns;
    timeprecision 100ps;

    import mem_pkg::*;
    import sq_pkg::*;

    logic                       clock;
    logic                       reset;
    logic [dispatch_bits-1:0]   stores_dispatching;
    logic                       resolve_valid;
    logic [sq_idx_bits-1:0]     resolve_idx;
    logic [addr_width-1:0]      resolve_addr;
    store_size_e                resolve_size;
    logic [data_width-1:0]      resolve_data;
    logic [dispatch_bits-1:0]   stores_retiring;
    logic                       restore_valid;
    logic [sq_ptr_bits-1:0]     restore_tail;
    logic [addr_width-1:0]      load_addr;
    logic [sq_ptr_bits-1:0]     load_tail;
    logic                       store_req_accepted;
    logic [dispatch_bits-1:0]   sq_spots;
    logic [sq_ptr_bits-1:0]     sq_tail;
    logic [sq_depth-1:0]        unresolved_mask;
    logic [data_width-1:0]      forward_data;
    logic [byte_lanes-1:0]      forward_mask;
    logic                       store_req_valid;
    logic [addr_width-1:0]      store_req_addr;
    logic [data_width-1:0]      store_req_data;
    logic [byte_lanes-1:0]      store_req_byte_mask;

    // one vector line, every field in hex
    logic [31:0] rnd, chk, disp, rv, ridx, raddr, rsize, rdata, ret, rsv, rtail;
    logic [31:0] laddr, ltail, acc;
    logic [31:0] e_spots, e_tail, e_unres, e_fdata, e_fmask;
    logic [31:0] e_valid, e_qaddr, e_qdata, e_qmask;

    logic [31:0] lfsr_state;
    int          vector_count;
    int          random_drains;

    store_subsystem dut_i (.*);

    always #20 clock = ~clock;

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        logic fb;
        fb = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], fb};
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAIL %s expected %h actual %h", name, expected, actual);
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    endtask

    function automatic bit is_vector_line(input string text);
        return text.len() > 1 && text[0] != "#";
    endfunction

    initial begin
        vector_count = 0;
        wait (vector_count > 0);
        #(vector_count * 40 + 2000);
        $display("watchdog expired before all vectors were applied");
        $display("SIMULATION FAILED");
        $fatal(1);
    end

    initial begin
        int          fd;
        int          fields;
        int          line_no;
        int          total;
        int          pending_retired;
        bit          drained;
        logic [31:0] spots_expected;
        string       text;
        string       tag;

        clock              = 1'b0;
        reset              = 1'b1;
        stores_dispatching = '0;
        resolve_valid      = 1'b0;
        resolve_idx        = '0;
        resolve_addr       = '0;
        resolve_size       = size_byte;
        resolve_data       = '0;
        stores_retiring    = '0;
        restore_valid      = 1'b0;
        restore_tail       = '0;
        load_addr          = '0;
        load_tail          = '0;
        store_req_accepted = 1'b0;
        lfsr_state         = 32'he317_3d2d;
        random_drains      = 0;
        pending_retired    = 0;

        // first pass only counts vectors for the watchdog
        total = 0;
        fd = $fopen("store_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open the vectors file");
            $display("SIMULATION FAILED");
            $fatal(1);
        end
        while ($fgets(text, fd) != 0) begin
            if (is_vector_line(text)) begin
                total++;
            end
        end
        $fclose(fd);
        vector_count = total;

        repeat (4) @(posedge clock);
        #2 reset = 1'b0;

        fd = $fopen("store_vectors.txt", "r");
        line_no = 0;
        while ($fgets(text, fd) != 0) begin
            line_no++;
            if (!is_vector_line(text)) begin
                continue;
            end
            fields = $sscanf(text,
                "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                rnd, chk, disp, rv, ridx, raddr, rsize, rdata, ret, rsv, rtail,
                laddr, ltail, acc, e_spots, e_tail, e_unres, e_fdata, e_fmask,
                e_valid, e_qaddr, e_qdata, e_qmask);
            if (fields != 23) begin
                $display("vectors file line %0d has the wrong number of fields", line_no);
                $display("SIMULATION FAILED");
                $fatal(1);
            end

            @(posedge clock);
            #2;
            stores_dispatching = disp[dispatch_bits-1:0];
            resolve_valid      = rv[0];
            resolve_idx        = ridx[sq_idx_bits-1:0];
            resolve_addr       = raddr;
            resolve_size       = store_size_e'(rsize[1:0]);
            resolve_data       = rdata;
            stores_retiring    = ret[dispatch_bits-1:0];
            restore_valid      = rsv[0];
            restore_tail       = rtail[sq_ptr_bits-1:0];
            load_addr          = laddr;
            load_tail          = ltail[sq_ptr_bits-1:0];
            if (rnd[0]) begin
                lfsr_state         = lfsr_step(lfsr_state);
                store_req_accepted = lfsr_state[0];
            end else begin
                store_req_accepted = acc[0];
            end

            // just before the next rising edge
            #37;
            tag = $sformatf("line %0d", line_no);
            check_value({tag, " sq_tail"}, e_tail, 32'(sq_tail));
            check_value({tag, " unresolved_mask"}, e_unres, 32'(unresolved_mask));
            if (chk[0]) begin
                check_value({tag, " sq_spots"}, e_spots, 32'(sq_spots));
            end
            if (chk[1]) begin
                check_value({tag, " forward_data"}, e_fdata, forward_data);
                check_value({tag, " forward_mask"}, e_fmask, 32'(forward_mask));
            end
            if (chk[2]) begin
                check_value({tag, " store_req_valid"}, e_valid, 32'(store_req_valid));
            end
            if (chk[3]) begin
                check_value({tag, " store_req_addr"}, e_qaddr, store_req_addr);
                check_value({tag, " store_req_data"}, e_qdata, store_req_data);
                check_value({tag, " store_req_byte_mask"}, e_qmask,
                            32'(store_req_byte_mask));
            end

            // each random drain frees one more slot, capped at the dispatch width
            if (rnd[0]) begin
                spots_expected = e_spots + random_drains;
                if (spots_expected > dispatch_width) begin
                    spots_expected = dispatch_width;
                end
                check_value({tag, " sq_spots"}, spots_expected, 32'(sq_spots));
            end

            // retired stores still waiting for the cache
            drained = pending_retired > 0 && store_req_accepted;
            if (rnd[0] && drained) begin
                random_drains++;
            end
            pending_retired = pending_retired + int'(ret[dispatch_bits-1:0]) - int'(drained);
        end
        $fclose(fd);

        $display("%0d vectors applied, %0d drains under random back-pressure",
                 vector_count, random_drains);
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

/* store_subsystem.sv */
module store_subsystem (
    input  logic                             clock,
    input  logic                             reset,
    input  logic [sq_pkg::dispatch_bits-1:0] stores_dispatching,
    input  logic                             resolve_valid,
    input  logic [sq_pkg::sq_idx_bits-1:0]   resolve_idx,
    input  logic [mem_pkg::addr_width-1:0]   resolve_addr,
    input  mem_pkg::store_size_e             resolve_size,
    input  logic [mem_pkg::data_width-1:0]   resolve_data,
    input  logic [sq_pkg::dispatch_bits-1:0] stores_retiring,
    input  logic                             restore_valid,
    input  logic [sq_pkg::sq_ptr_bits-1:0]   restore_tail,
    input  logic [mem_pkg::addr_width-1:0]   load_addr,
    input  logic [sq_pkg::sq_ptr_bits-1:0]   load_tail,
    input  logic                             store_req_accepted,
    output logic [sq_pkg::dispatch_bits-1:0] sq_spots,
    output logic [sq_pkg::sq_ptr_bits-1:0]   sq_tail,
    output logic [sq_pkg::sq_depth-1:0]      unresolved_mask,
    output logic [mem_pkg::data_width-1:0]   forward_data,
    output logic [mem_pkg::byte_lanes-1:0]   forward_mask,
    output logic                             store_req_valid,
    output logic [mem_pkg::addr_width-1:0]   store_req_addr,
    output logic [mem_pkg::data_width-1:0]   store_req_data,
    output logic [mem_pkg::byte_lanes-1:0]   store_req_byte_mask
);
    import mem_pkg::*;
    import sq_pkg::*;

    // formatted entry from the execution stage
    logic [sq_depth-1:0]        entry_write;
    logic [word_addr_width-1:0] entry_addr;
    logic [data_width-1:0]      entry_data;
    logic [byte_lanes-1:0]      entry_byte_mask;

    store_format u_format (
        .resolve_valid   (resolve_valid),
        .resolve_idx     (resolve_idx),
        .resolve_addr    (resolve_addr),
        .resolve_size    (resolve_size),
        .resolve_data    (resolve_data),
        .entry_write     (entry_write),
        .entry_addr      (entry_addr),
        .entry_data      (entry_data),
        .entry_byte_mask (entry_byte_mask)
    );

    store_queue u_queue (
        .clock               (clock),
        .reset               (reset),
        .stores_dispatching  (stores_dispatching),
        .entry_write         (entry_write),
        .entry_addr          (entry_addr),
        .entry_data          (entry_data),
        .entry_byte_mask     (entry_byte_mask),
        .stores_retiring     (stores_retiring),
        .restore_valid       (restore_valid),
        .restore_tail        (restore_tail),
        .load_addr           (load_addr),
        .load_tail           (load_tail),
        .store_req_accepted  (store_req_accepted),
        .sq_spots            (sq_spots),
        .sq_tail             (sq_tail),
        .unresolved_mask     (unresolved_mask),
        .forward_data        (forward_data),
        .forward_mask        (forward_mask),
        .store_req_valid     (store_req_valid),
        .store_req_addr      (store_req_addr),
        .store_req_data      (store_req_data),
        .store_req_byte_mask (store_req_byte_mask)
    );

endmodule

/* store_queue.sv */
module store_queue (
    input  logic                                clock,
    input  logic                                reset,
    input  logic [sq_pkg::dispatch_bits-1:0]    stores_dispatching,
    input  logic [sq_pkg::sq_depth-1:0]         entry_write,
    input  logic [mem_pkg::word_addr_width-1:0] entry_addr,
    input  logic [mem_pkg::data_width-1:0]      entry_data,
    input  logic [mem_pkg::byte_lanes-1:0]      entry_byte_mask,
    input  logic [sq_pkg::dispatch_bits-1:0]    stores_retiring,
    input  logic                                restore_valid,
    input  logic [sq_pkg::sq_ptr_bits-1:0]      restore_tail,
    input  logic [mem_pkg::addr_width-1:0]      load_addr,
    input  logic [sq_pkg::sq_ptr_bits-1:0]      load_tail,
    input  logic                                store_req_accepted,
    output logic [sq_pkg::dispatch_bits-1:0]    sq_spots,
    output logic [sq_pkg::sq_ptr_bits-1:0]      sq_tail,
    output logic [sq_pkg::sq_depth-1:0]         unresolved_mask,
    output logic [mem_pkg::data_width-1:0]      forward_data,
    output logic [mem_pkg::byte_lanes-1:0]      forward_mask,
    output logic                                store_req_valid,
    output logic [mem_pkg::addr_width-1:0]      store_req_addr,
    output logic [mem_pkg::data_width-1:0]      store_req_data,
    output logic [mem_pkg::byte_lanes-1:0]      store_req_byte_mask
);
    import mem_pkg::*;
    import sq_pkg::*;

    // entry storage
    logic [sq_depth-1:0][word_addr_width-1:0] addr_q;
    logic [sq_depth-1:0][data_width-1:0]      data_q;
    logic [sq_depth-1:0][byte_lanes-1:0]      mask_q;

    logic [sq_ptr_bits-1:0]   retire_head;
    logic [sq_ptr_bits-1:0]   drain_head;
    logic [sq_ptr_bits-1:0]   next_drain_head;
    logic [sq_ptr_bits-1:0]   keep_span;
    logic [sq_count_bits-1:0] sq_count;
    logic [sq_count_bits-1:0] retired_count;
    logic [sq_count_bits-1:0] free_slots;
    logic [sq_depth-1:0]      unresolved;
    logic [sq_depth-1:0]      dispatch_slots;
    logic [sq_depth-1:0]      survive;
    logic [sq_depth-1:0]      write_keep;
    logic [sq_idx_bits-1:0]   drain_idx;
    logic                     drain_fire;

    assign free_slots = sq_count_bits'(sq_depth) - sq_count;
    assign sq_spots   = (free_slots < sq_count_bits'(dispatch_width))
                        ? dispatch_bits'(free_slots) : dispatch_bits'(dispatch_width);

    // a store resolving this cycle already counts as resolved
    assign unresolved_mask = unresolved & ~entry_write;

    // oldest retired entry goes to the cache
    assign drain_idx           = drain_head[sq_idx_bits-1:0];
    assign store_req_valid     = retired_count != '0;
    assign store_req_addr      = {addr_q[drain_idx], lane_bits'(0)};
    assign store_req_data      = data_q[drain_idx];
    assign store_req_byte_mask = mask_q[drain_idx];
    assign drain_fire          = store_req_valid && store_req_accepted;
    assign next_drain_head     = drain_head + sq_ptr_bits'(drain_fire);

    // speculative stores that a restore keeps
    assign keep_span = restore_tail - retire_head;

    always_comb begin
        logic [sq_idx_bits-1:0] from_tail;
        logic [sq_idx_bits-1:0] from_retire;
        for (int i = 0; i < sq_depth; i++) begin
            from_tail         = sq_idx_bits'(i) - sq_tail[sq_idx_bits-1:0];
            from_retire       = sq_idx_bits'(i) - retire_head[sq_idx_bits-1:0];
            dispatch_slots[i] = !restore_valid && ({1'b0, from_tail} < stores_dispatching);
            survive[i]        = {1'b0, from_retire} < keep_span;
        end
    end

    // a resolve into a squashed slot is dropped
    assign write_keep = restore_valid ? (entry_write & survive) : entry_write;

    always_ff @(posedge clock) begin
        if (reset) begin
            sq_tail       <= '0;
            retire_head   <= '0;
            drain_head    <= '0;
            sq_count      <= '0;
            retired_count <= '0;
            unresolved    <= '0;
            mask_q        <= '0;
        end else begin
            retire_head   <= retire_head + sq_ptr_bits'(stores_retiring);
            drain_head    <= next_drain_head;
            retired_count <= retired_count + sq_count_bits'(stores_retiring)
                             - sq_count_bits'(drain_fire);
            if (restore_valid) begin
                sq_tail    <= restore_tail;
                // equal index with opposite wrap bit reads as full
                sq_count   <= sq_count_bits'(restore_tail - next_drain_head);
                unresolved <= unresolved_mask & survive;
            end else begin
                sq_tail    <= sq_tail + sq_ptr_bits'(stores_dispatching);
                sq_count   <= sq_count + sq_count_bits'(stores_dispatching)
                              - sq_count_bits'(drain_fire);
                unresolved <= unresolved_mask | dispatch_slots;
            end
            // new slots start with no bytes so they never forward stale data
            for (int i = 0; i < sq_depth; i++) begin
                if (write_keep[i]) begin
                    mask_q[i] <= entry_byte_mask;
                end else if (dispatch_slots[i]) begin
                    mask_q[i] <= '0;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < sq_depth; i++) begin
            if (write_keep[i]) begin
                addr_q[i] <= entry_addr;
                data_q[i] <= entry_data;
            end
        end
    end

    store_forward u_forward (
        .load_addr      (load_addr),
        .load_tail      (load_tail),
        .drain_head     (drain_head),
        .entry_addr_all (addr_q),
        .entry_mask_all (mask_q),
        .entry_data_all (data_q),
        .forward_data   (forward_data),
        .forward_mask   (forward_mask)
    );

endmodule

/* store_forward.sv */
module store_forward (
    input  logic [mem_pkg::addr_width-1:0]                        load_addr,
    input  logic [sq_pkg::sq_ptr_bits-1:0]                        load_tail,
    input  logic [sq_pkg::sq_ptr_bits-1:0]                        drain_head,
    input  logic [sq_pkg::sq_depth*mem_pkg::word_addr_width-1:0]  entry_addr_all,
    input  logic [sq_pkg::sq_depth*mem_pkg::byte_lanes-1:0]       entry_mask_all,
    input  logic [sq_pkg::sq_depth*mem_pkg::data_width-1:0]       entry_data_all,
    output logic [mem_pkg::data_width-1:0]                        forward_data,
    output logic [mem_pkg::byte_lanes-1:0]                        forward_mask
);
    import mem_pkg::*;
    import sq_pkg::*;

    logic [word_addr_width-1:0] load_word;
    logic [sq_idx_bits-1:0]     tail_idx;
    logic [sq_ptr_bits-1:0]     live;
    logic [sq_depth-1:0]        window;

    assign load_word = load_addr[addr_width-1:lane_bits];
    assign tail_idx  = load_tail[sq_idx_bits-1:0];

    // undrained stores older than the load, zero when the pointers are equal
    assign live = load_tail - drain_head;

    // older stores occupy the top live positions after rotation
    // a drain head already past the load tail leaves nothing to forward
    always_comb begin
        window = '0;
        for (int p = 0; p < sq_depth; p++) begin
            if (int'(live) <= sq_depth && p >= sq_depth - int'(live)) begin
                window[p] = 1'b1;
            end
        end
    end

    for (genvar lane = 0; lane < byte_lanes; lane++) begin : g_lane
        logic [sq_depth-1:0]  hit_rot;
        logic [sq_depth-1:0]  pick;
        logic [byte_bits-1:0] lane_byte;
        logic                 lane_hit;

        // position p holds entry tail_idx + p, the entry just below the tail on top
        always_comb begin
            logic [sq_idx_bits-1:0] idx;
            for (int p = 0; p < sq_depth; p++) begin
                idx        = tail_idx + sq_idx_bits'(p);
                hit_rot[p] = window[p]
                    && entry_mask_all[idx*byte_lanes + lane]
                    && entry_addr_all[idx*word_addr_width +: word_addr_width] == load_word;
            end
        end

        newest_select u_newest (
            .req (hit_rot),
            .gnt (pick)
        );

        // map the winning position back to its entry
        always_comb begin
            logic [sq_idx_bits-1:0] idx;
            lane_byte = '0;
            lane_hit  = 1'b0;
            for (int p = 0; p < sq_depth; p++) begin
                idx = tail_idx + sq_idx_bits'(p);
                if (pick[p]) begin
                    lane_byte = entry_data_all[idx*data_width + lane*byte_bits +: byte_bits];
                    lane_hit  = 1'b1;
                end
            end
        end

        assign forward_data[lane*byte_bits +: byte_bits] = lane_byte;
        assign forward_mask[lane]                        = lane_hit;
    end

endmodule

/* store_format.sv */
module store_format (
    input  logic                               resolve_valid,
    input  logic [sq_pkg::sq_idx_bits-1:0]     resolve_idx,
    input  logic [mem_pkg::addr_width-1:0]     resolve_addr,
    input  mem_pkg::store_size_e               resolve_size,
    input  logic [mem_pkg::data_width-1:0]     resolve_data,
    output logic [sq_pkg::sq_depth-1:0]        entry_write,
    output logic [mem_pkg::word_addr_width-1:0] entry_addr,
    output logic [mem_pkg::data_width-1:0]     entry_data,
    output logic [mem_pkg::byte_lanes-1:0]     entry_byte_mask
);
    import mem_pkg::*;
    import sq_pkg::*;

    logic [lane_bits-1:0]  offset;
    logic [lane_bits-1:0]  lane_shift;
    logic [byte_lanes-1:0] base_mask;

    assign offset     = resolve_addr[lane_bits-1:0];
    assign entry_addr = resolve_addr[addr_width-1:lane_bits];

    // lowest lane touched and the lane pattern for each size
    always_comb begin
        case (resolve_size)
            size_byte: begin
                lane_shift = offset;
                base_mask  = byte_lanes'(1);
            end
            size_half: begin
                // halves sit on an even lane
                lane_shift = {offset[lane_bits-1:1], 1'b0};
                base_mask  = byte_lanes'(3);
            end
            default: begin
                lane_shift = '0;
                base_mask  = '1;
            end
        endcase
    end

    // low bytes of the raw data move up into their lanes
    assign entry_data      = resolve_data << (lane_shift * byte_bits);
    assign entry_byte_mask = base_mask << lane_shift;

    assign entry_write = resolve_valid ? (sq_depth'(1) << resolve_idx) : '0;

endmodule

/* newest_select.sv */
module newest_select (
    input  logic [sq_pkg::sq_depth-1:0] req,
    output logic [sq_pkg::sq_depth-1:0] gnt
);
    import sq_pkg::*;

    // scan upwards so the highest set request wins
    always_comb begin
        gnt = '0;
        for (int i = 0; i < sq_depth; i++) begin
            if (req[i]) begin
                gnt    = '0;
                gnt[i] = 1'b1;
            end
        end
    end

endmodule

/* sq_pkg.sv */
package sq_pkg;

    // queue entries and the index into them
    localparam int sq_depth    = 8;
    localparam int sq_idx_bits = $clog2(sq_depth);

    // index plus one wrap bit, so full and empty differ
    localparam int sq_ptr_bits = sq_idx_bits + 1;

    // most stores that dispatch or retire in one cycle
    localparam int dispatch_width = 2;
    localparam int dispatch_bits  = $clog2(dispatch_width + 1);

    // occupancy counts from 0 to sq_depth
    localparam int sq_count_bits = $clog2(sq_depth + 1);

endpackage

/* mem_pkg.sv */
package mem_pkg;

    // byte address and one data word
    localparam int addr_width = 32;
    localparam int data_width = 32;

    // bytes per word and the offset bits that pick a lane
    localparam int byte_bits  = 8;
    localparam int byte_lanes = data_width / byte_bits;
    localparam int lane_bits  = $clog2(byte_lanes);

    // address of a whole word with the lane offset dropped
    localparam int word_addr_width = addr_width - lane_bits;

    // access size of a store
    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } store_size_e;

endpackage
